/* Bender.yml */
package:
  name: uart6551

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart6551Pkg.sv
      - verilog/uart6551If.sv
      - verilog/uart6551BaudLut.sv
      - verilog/uart6551BaudGen.sv
      - verilog/uart6551Regs.sv
      - verilog/uart6551Tx.sv
      - verilog/uart6551Rx.sv
      - verilog/uart6551.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/uart6551_chk.sv
      - sim/uart6551Tb.sv

/* sim/uart6551Tb.sv */
`timescale 1ns/1ps
`include "uart6551_cfg.svh"
`default_nettype none

module uart6551Tb;
	import uart6551Pkg::*;

	typedef logic [`UART_CNT_BITS-1:0] cntT;

	localparam int clkPeriod  = 4;
	localparam int numFrames  = 15;	// 8 loopback, 3 timing, 2 overrun, 1 framing, 1 halt
	localparam int haltCycles = 4000;

	logic       clk = 1'b0;
	logic       rst, cs, we, tbRxd, loopback;
	logic [1:0] adr;
	logic [7:0] dati, stat;
	wire  [7:0] dato;
	wire        txd, rxd;
	logic       dataRead = 1'b0;	// a REG_DATA read is on dato
	logic [7:0] expQ [$];	// bytes the compare process still expects
	int         baudSel;	// index last written to control
	int         wdCycles;
	int         timeIdx [3] = '{21, 20, 19};
	cntT        bitClks;

	// standard 6551 rates by baud index
	real stdRates [0:21] = '{0.0, 50.0, 75.0, 109.92, 134.58, 150.0, 300.0, 600.0,
		1200.0, 1800.0, 2400.0, 3600.0, 4800.0, 7200.0, 9600.0, 19200.0,
		38400.0, 57600.0, 115200.0, 230400.0, 460800.0, 921600.0};

	assign rxd = loopback ? txd : tbRxd;	// serial loopback or driven frames

	uart6551 uart6551_i (.clk(clk), .rst(rst), .cs(cs), .we(we), .adr(adr), .dati(dati),
		.dato(dato), .rxd(rxd), .txd(txd));

	always #(clkPeriod / 2) clk = ~clk;

	// ======================================================================
	// reference model and checks
	// ======================================================================
	function automatic cntT refDivisor(input int idx);
		real rate;
		if (idx == 0)
			return '0;	// generator stopped
		rate = (idx > 21) ? 9600.0 : stdRates[idx];
		return cntT'($rtoi(real'(`UART_CLK_HZ) / (16.0 * rate) + 0.5));
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abortRun($sformatf("Error: %s = 0x%02h, expected 0x%02h", name, got, exp));
	endtask

	task automatic checkStatus(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abortRun($sformatf("Error: %s = 0x%02h, expected 0x%02h", name, got, exp));
	endtask

	task automatic checkDivisor(input string name, input cntT got, input cntT exp);
		if (got !== exp)
			abortRun($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic checkLine(input string name, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// ======================================================================
	// bus and serial drivers
	// ======================================================================
	task automatic busWrite(input regAddrE a, input logic [7:0] d);
		@(posedge clk);
		cs   <= 1'b1;
		we   <= 1'b1;
		adr  <= a;
		dati <= d;
		@(posedge clk);	// DUT takes the write here
		cs <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic busRead(input regAddrE a, output logic [7:0] d);
		@(posedge clk);
		cs  <= 1'b1;
		we  <= 1'b0;
		adr <= a;
		@(posedge clk);
		cs <= 1'b0;
		@(negedge clk);	// registered dato is stable here
		d = dato;
	endtask

	task automatic setBaud(input int idx);
		busWrite(REG_CONTROL, 8'(idx));
		baudSel = idx;
	endtask

	task automatic waitRxFull();
		logic [7:0] s;
		do
			busRead(REG_STATUS, s);
		while (!s[0]);
	endtask

	task automatic sendFrame(input logic [7:0] d, input bit goodStop);
		int bitLen;
		bitLen = 16 * refDivisor(baudSel);
		@(posedge clk);
		tbRxd <= 1'b0;	// start bit
		repeat (bitLen) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			tbRxd <= d[i];	// lsb first
			repeat (bitLen) @(posedge clk);
		end
		// a low stop ends early so its tail reads as a false start
		tbRxd <= goodStop;
		repeat (bitLen * 3 / 4) @(posedge clk);
		tbRxd <= 1'b1;
		repeat (bitLen - bitLen * 3 / 4) @(posedge clk);
	endtask

	// compare process for every data register read
	always @(posedge clk)
		dataRead <= cs && !we && (adr == REG_DATA);

	always @(negedge clk) begin
		if (dataRead) begin
			if (expQ.size() == 0)
				abortRun("data register read while no byte was expected");
			else
				checkByte("dato", dato, expQ.pop_front());
		end
	end

	// assertion failures in the bound checker
	always @(posedge clk)
		if (uart6551_i.chk_i.failCnt != 0)
			abortRun("an assertion in the checker failed");

	// watchdog budget is twice the frames at index 19 plus the halt window
	initial begin
		wdCycles = 2 * (numFrames * 10 * 16 * refDivisor(19) + haltCycles);
		repeat (wdCycles) @(posedge clk);
		abortRun("watchdog expired before the tests completed");
	end

	// ======================================================================
	// stimulus
	// ======================================================================
	initial begin
		void'($urandom(32'h61cb6ae8));
		rst      <= 1'b1;
		cs       <= 1'b0;
		we       <= 1'b0;
		adr      <= 2'd0;
		dati     <= 8'h00;
		tbRxd    <= 1'b1;
		loopback <= 1'b0;
		baudSel  = `UART_RESET_BAUD;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// reset values
		busRead(REG_STATUS, stat);
		checkStatus("status", stat, 8'h02);
		busRead(REG_CONTROL, stat);
		checkByte("control", stat, 8'(`UART_RESET_BAUD));
		busRead(REG_COMMAND, stat);
		checkByte("command", stat, 8'h01);
		checkLine("txd", txd, 1'b1);

		// loopback of random bytes
		@(posedge clk);
		loopback <= 1'b1;
		setBaud(21);
		repeat (8) begin
			stat = 8'($urandom);
			expQ.push_back(stat);
			busWrite(REG_DATA, stat);
			waitRxFull();
			busRead(REG_STATUS, stat);
			checkStatus("status", stat, 8'h03);	// rxFull, txEmpty
			busRead(REG_DATA, stat);
		end
		busRead(REG_STATUS, stat);
		checkStatus("status", stat, 8'h02);

		// start bit length with rxd held idle
		@(posedge clk);
		loopback <= 1'b0;
		foreach (timeIdx[k]) begin
			setBaud(timeIdx[k]);
			busWrite(REG_DATA, 8'($urandom) | 8'h01);	// first data bit high
			@(negedge clk);
			while (txd) @(negedge clk);
			bitClks = '0;
			while (!txd) begin
				bitClks++;
				@(negedge clk);
			end
			checkDivisor("start bit clocks", bitClks, cntT'(16 * refDivisor(timeIdx[k])));
			repeat (10 * 16 * refDivisor(timeIdx[k])) @(negedge clk);	// rest of frame
		end

		// overrun keeps the first byte
		setBaud(21);
		stat = 8'($urandom);
		expQ.push_back(stat);
		sendFrame(stat, 1'b1);
		sendFrame(~stat, 1'b1);
		busRead(REG_STATUS, stat);
		checkStatus("status", stat, 8'h07);
		busRead(REG_DATA, stat);
		busRead(REG_STATUS, stat);
		checkStatus("status", stat, 8'h02);

		// framing error stays until a status write
		stat = 8'($urandom);
		expQ.push_back(stat);
		sendFrame(stat, 1'b0);
		busRead(REG_STATUS, stat);
		checkStatus("status", stat, 8'h0b);
		busRead(REG_DATA, stat);
		busRead(REG_STATUS, stat);
		checkStatus("status", stat, 8'h0a);
		busWrite(REG_STATUS, 8'h00);
		busRead(REG_STATUS, stat);
		checkStatus("status", stat, 8'h02);

		// index 0 holds the byte until a real rate is set
		@(posedge clk);
		loopback <= 1'b1;
		setBaud(0);
		stat = 8'($urandom);
		expQ.push_back(stat);
		busWrite(REG_DATA, stat);
		repeat (haltCycles) begin
			@(negedge clk);
			checkLine("txd", txd, 1'b1);
		end
		busRead(REG_STATUS, stat);
		checkStatus("status", stat, 8'h00);	// byte still held
		setBaud(21);
		waitRxFull();
		busRead(REG_DATA, stat);
		busRead(REG_STATUS, stat);
		checkStatus("status", stat, 8'h02);

		if (expQ.size() != 0)
			abortRun("a byte sent was never read back");
		else if (uart6551_i.chk_i.failCnt != 0)
			abortRun("an assertion in the checker failed");
		else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sim/uart6551_chk.sv */
`timescale 1ns/1ps
`include "uart6551_cfg.svh"
`default_nettype none

module uart6551_chk (
	input wire logic                      clk,
	input wire logic                      rst,
	input wire logic                      txd,
	input wire uart6551Pkg::txStateE      txState,
	input wire logic                      baudTick,
	input wire logic [`UART_CNT_BITS-1:0] div,	// table output inside the baud generator
	input wire logic                      rxStrobe
);
	import uart6551Pkg::*;

	int failCnt = 0;	// assertion failures so far

	// line sits at mark whenever the transmitter is idle
	idleMark: assert property (@(posedge clk) disable iff (rst) (txState == TX_IDLE) |-> txd)
		else begin
			failCnt++;
			$error("txd low while the transmitter is idle");
		end

	// index 0 stops the generator
	noTickStopped: assert property (@(posedge clk) disable iff (rst) (div == '0) |-> !baudTick)
		else begin
			failCnt++;
			$error("baud tick while the divisor is zero");
		end

	rxStrobeSingle: assert property (@(posedge clk) disable iff (rst) rxStrobe |=> !rxStrobe)
		else begin
			failCnt++;
			$error("receive strobe held for two cycles");
		end

endmodule

bind uart6551 uart6551_chk chk_i (
	.clk      (clk),
	.rst      (rst),
	.txd      (txd),
	.txState  (uTx.state),
	.baudTick (bus.baudTick),
	.div      (uBaudGen.div),
	.rxStrobe (bus.rxStrobe)
);

`default_nettype wire

/* uart6551.f */
+incdir+verilog
verilog/uart6551Pkg.sv
verilog/uart6551If.sv
verilog/uart6551BaudLut.sv
verilog/uart6551BaudGen.sv
verilog/uart6551Regs.sv
verilog/uart6551Tx.sv
verilog/uart6551Rx.sv
verilog/uart6551.sv
sim/uart6551_chk.sv
sim/uart6551Tb.sv

/* verilog/uart6551.sv */
`timescale 1ns/1ps
`default_nettype none

module uart6551 (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       cs,	// bus strobe
	input  wire logic       we,
	input  wire logic [1:0] adr,
	input  wire logic [7:0] dati,
	output wire logic [7:0] dato,
	input  wire logic       rxd,
	output wire logic       txd
);
	import uart6551Pkg::*;

	wire [4:0] baudIdx;	// control register to baud generator

	uart6551If bus ();

	uart6551Regs uRegs (
		.clk     (clk),
		.rst     (rst),
		.cs      (cs),
		.we      (we),
		.adr     (regAddrE'(adr)),
		.dati    (dati),
		.dato    (dato),
		.baudIdx (baudIdx),
		.bus     (bus.regs)
	);

	uart6551BaudGen uBaudGen (.clk(clk), .rst(rst), .baudIdx(baudIdx), .bus(bus.gen));

	uart6551Tx uTx (.clk(clk), .rst(rst), .txd(txd), .bus(bus.tx));

	uart6551Rx uRx (.clk(clk), .rst(rst), .rxd(rxd), .bus(bus.rx));

endmodule

`default_nettype wire

/* verilog/uart6551BaudGen.sv */
`timescale 1ns/1ps
`include "uart6551_cfg.svh"
`default_nettype none

module uart6551BaudGen (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic [4:0] baudIdx,
	uart6551If.gen          bus
);

	logic [`UART_CNT_BITS-1:0] div;	// table output
	logic [`UART_CNT_BITS-1:0] cnt;	// counts down to the next tick
	logic [4:0]                idxQ;	// index the count was started with
	logic                      restart;

	uart6551BaudLut uLut (.a(baudIdx), .o(div));

	assign restart = (baudIdx != idxQ);

	// tick on reload, never while stopped or restarting
	assign bus.baudTick = (cnt == '0) && (div != '0) && !restart;

	always_ff @(posedge clk) begin
		if (rst) begin
			idxQ <= '0;	// forces a restart once the index settles
			cnt  <= '0;
		end else if (restart) begin
			idxQ <= baudIdx;
			cnt  <= (div == '0) ? '0 : div - 1'b1;
		end else if (div == '0) begin
			cnt <= '0;	// index 0, hold
		end else if (cnt == '0) begin
			cnt <= div - 1'b1;	// reload, period of div clocks
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/uart6551BaudLut.sv */
`timescale 1ns/1ps
`include "uart6551_cfg.svh"
`default_nettype none

module uart6551BaudLut (
	input  wire logic [4:0]                a,	// baud index
	output logic      [`UART_CNT_BITS-1:0] o	// clocks per 16x tick
);

	// clk / (16 * baud), rounded; rate given in hundredths of a baud
	// so the odd teletype rates come out right
	function automatic logic [`UART_CNT_BITS-1:0] baudDiv(input longint cbaud);
		longint q;
		q = (longint'(`UART_CLK_HZ) * 100 + 8 * cbaud) / (16 * cbaud);
		return q[`UART_CNT_BITS-1:0];
	endfunction

	always_comb begin
		case (a)
		5'd0:    o = '0;	// generator stopped
		5'd1:    o = baudDiv(5000);	// 50
		5'd2:    o = baudDiv(7500);	// 75
		5'd3:    o = baudDiv(10992);	// 109.92
		5'd4:    o = baudDiv(13458);	// 134.58
		5'd5:    o = baudDiv(15000);	// 150
		5'd6:    o = baudDiv(30000);	// 300
		5'd7:    o = baudDiv(60000);	// 600
		5'd8:    o = baudDiv(120000);	// 1200
		5'd9:    o = baudDiv(180000);	// 1800
		5'd10:   o = baudDiv(240000);	// 2400
		5'd11:   o = baudDiv(360000);	// 3600
		5'd12:   o = baudDiv(480000);	// 4800
		5'd13:   o = baudDiv(720000);	// 7200
		5'd14:   o = baudDiv(960000);	// 9600
		5'd15:   o = baudDiv(1920000);	// 19200
		5'd16:   o = baudDiv(3840000);	// 38400
		5'd17:   o = baudDiv(5760000);	// 57600
		5'd18:   o = baudDiv(11520000);	// 115200
		5'd19:   o = baudDiv(23040000);	// 230400
		5'd20:   o = baudDiv(46080000);	// 460800
		5'd21:   o = baudDiv(92160000);	// 921600
		default: o = baudDiv(960000);	// unused codes fall back to 9600
		endcase
	end

endmodule

`default_nettype wire

/* verilog/uart6551If.sv */
`timescale 1ns/1ps
`default_nettype none

// links the register block with the serial engines
interface uart6551If;
	logic [7:0] txHold;	// byte waiting for the transmitter
	logic       txHoldFull;
	logic       txTake;	// tx grabbed txHold this cycle
	logic [7:0] rxByte;	// last assembled byte
	logic       rxStrobe;	// one cycle, byte + error valid
	logic       rxFrameErr;	// stop sample was low
	logic       rxEnable;
	logic       baudTick;	// 16x oversampling tick

	modport regs (
		output txHold, txHoldFull, rxEnable,
		input  txTake, rxByte, rxStrobe, rxFrameErr
	);

	modport tx (
		input  txHold, txHoldFull, baudTick,
		output txTake
	);

	modport rx (
		input  rxEnable, baudTick,
		output rxByte, rxStrobe, rxFrameErr
	);

	modport gen (output baudTick);
endinterface

`default_nettype wire

/* verilog/uart6551Pkg.sv */
`default_nettype none

package uart6551Pkg;

	// register map seen on the byte bus
	typedef enum logic [1:0] {
		REG_DATA    = 2'd0,	// tx holding on write, rx buffer on read
		REG_STATUS  = 2'd1,	// flags, write clears framing error
		REG_COMMAND = 2'd2,	// bit 0 receiver enable
		REG_CONTROL = 2'd3	// baud index in bits 4..0
	} regAddrE;

	// transmitter frame phases
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} txStateE;

	// receiver frame phases
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rxStateE;

endpackage

`default_nettype wire

/* verilog/uart6551Regs.sv */
`timescale 1ns/1ps
`include "uart6551_cfg.svh"
`default_nettype none

module uart6551Regs (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  cs,
	input  wire logic                  we,
	input  wire uart6551Pkg::regAddrE  adr,
	input  wire logic [7:0]            dati,
	output logic      [7:0]            dato,
	output logic      [4:0]            baudIdx,
	uart6551If.regs                    bus
);
	import uart6551Pkg::*;

	logic       rd, wr;
	logic       rdData, wrData, wrStatus, wrCommand, wrControl;
	logic [7:0] rxData;	// receive buffer
	logic       rxFull, overrun, framingErr;
	logic [7:0] rdMux;

	// ==================================================================
	// bus decode
	// ==================================================================
	assign rd        = cs & ~we;
	assign wr        = cs & we;
	assign rdData    = rd && (adr == REG_DATA);
	assign wrData    = wr && (adr == REG_DATA);
	assign wrStatus  = wr && (adr == REG_STATUS);
	assign wrCommand = wr && (adr == REG_COMMAND);
	assign wrControl = wr && (adr == REG_CONTROL);

	// ==================================================================
	// transmit holding register
	// ==================================================================
	always_ff @(posedge clk) begin
		if (rst)
			bus.txHoldFull <= 1'b0;
		else if (wrData)
			bus.txHoldFull <= 1'b1;	// new byte wins over a take
		else if (bus.txTake)
			bus.txHoldFull <= 1'b0;
	end

	always_ff @(posedge clk)
		if (wrData) bus.txHold <= dati;	// overwrites a pending byte

	// ==================================================================
	// receive buffer and flags
	// ==================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			rxFull     <= 1'b0;
			overrun    <= 1'b0;
			framingErr <= 1'b0;
		end else begin
			if (bus.rxStrobe) begin
				if (rxFull) overrun <= 1'b1;	// new byte dropped
				else        rxFull  <= 1'b1;
				if (bus.rxFrameErr) framingErr <= 1'b1;
			end
			// clears override a same-cycle set
			if (rdData) begin
				rxFull  <= 1'b0;
				overrun <= 1'b0;
			end
			if (wrStatus) framingErr <= 1'b0;
		end
	end

	always_ff @(posedge clk)
		if (bus.rxStrobe && !rxFull) rxData <= bus.rxByte;	// old byte kept on overrun

	// command and control
	always_ff @(posedge clk) begin
		if (rst) begin
			bus.rxEnable <= 1'b1;
			baudIdx      <= `UART_RESET_BAUD;
		end else begin
			if (wrCommand) bus.rxEnable <= dati[0];
			if (wrControl) baudIdx <= dati[4:0];
		end
	end

	// read mux, registered
	always_comb begin
		case (adr)
		REG_DATA:    rdMux = rxData;
		REG_STATUS:  rdMux = {4'b0, framingErr, overrun, ~bus.txHoldFull, rxFull};
		REG_COMMAND: rdMux = {7'b0, bus.rxEnable};
		REG_CONTROL: rdMux = {3'b0, baudIdx};
		default:     rdMux = 8'h00;
		endcase
	end

	always_ff @(posedge clk)
		if (rd) dato <= rdMux;

endmodule

`default_nettype wire

/* verilog/uart6551Rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart6551Rx (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic rxd,
	uart6551If.rx     bus
);
	import uart6551Pkg::*;

	rxStateE    state;
	logic       rxS1, rxS2;	// two-flop synchroniser
	logic [3:0] tickCnt;
	logic [2:0] bitCnt;
	logic [7:0] shift;	// lsb arrives first, enters at the top
	logic       midBit;

	always_ff @(posedge clk) begin
		if (rst) begin
			rxS1 <= 1'b1;	// line idles high
			rxS2 <= 1'b1;
		end else begin
			rxS1 <= rxd;
			rxS2 <= rxS1;
		end
	end

	// ==================================================================
	// frame FSM
	// ==================================================================
	assign midBit = bus.baudTick && (tickCnt == 4'd15);

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= RX_IDLE;
			tickCnt      <= '0;
			bitCnt       <= '0;
			bus.rxStrobe <= 1'b0;
		end else begin
			bus.rxStrobe <= 1'b0;
			if (bus.baudTick) tickCnt <= tickCnt + 1'b1;
			case (state)
			RX_IDLE: if (bus.rxEnable && !rxS2) begin
				state   <= RX_START;	// falling edge seen
				tickCnt <= '0;
			end
			RX_START: if (bus.baudTick && tickCnt == 4'd7) begin
				tickCnt <= '0;	// now aligned to mid-bit
				bitCnt  <= '0;
				state   <= rxS2 ? RX_IDLE : RX_DATA;	// high means glitch
			end
			RX_DATA: if (midBit) begin
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == 3'd7) state <= RX_STOP;
			end
			RX_STOP: if (midBit) begin
				bus.rxStrobe <= 1'b1;	// valid the cycle after the stop sample
				state        <= RX_IDLE;
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && midBit) shift <= {rxS2, shift[7:1]};
		if (state == RX_STOP && midBit) bus.rxFrameErr <= ~rxS2;	// stop must be mark
	end

	assign bus.rxByte = shift;	// holds steady while idle

endmodule

`default_nettype wire

/* verilog/uart6551Tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart6551Tx (
	input  wire logic clk,
	input  wire logic rst,
	output logic      txd,
	uart6551If.tx     bus
);
	import uart6551Pkg::*;

	txStateE    state;
	logic [3:0] tickCnt;	// 16 ticks per bit
	logic [2:0] bitCnt;	// data bit number
	logic [7:0] shift;	// lsb goes out first
	logic       bitEnd;

	// frame starts on a tick only, so start bit is a full 16 ticks
	assign bus.txTake = (state == TX_IDLE) && bus.baudTick && bus.txHoldFull;
	assign bitEnd     = bus.baudTick && (tickCnt == 4'd15);

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= TX_IDLE;
			tickCnt <= '0;
			bitCnt  <= '0;
		end else begin
			if (bus.baudTick) tickCnt <= tickCnt + 1'b1;
			case (state)
			TX_IDLE: if (bus.txTake) begin
				state   <= TX_START;
				tickCnt <= '0;
			end
			TX_START: if (bitEnd) begin
				state  <= TX_DATA;
				bitCnt <= '0;
			end
			TX_DATA: if (bitEnd) begin
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == 3'd7) state <= TX_STOP;	// last data bit done
			end
			TX_STOP: if (bitEnd) state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (bus.txTake)               shift <= bus.txHold;
		else if (state == TX_DATA && bitEnd) shift <= {1'b0, shift[7:1]};
	end

	// line level per phase, mark when idle
	always_comb begin
		case (state)
		TX_START: txd = 1'b0;
		TX_DATA:  txd = shift[0];
		default:  txd = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/uart6551_cfg.svh */
`ifndef UART6551_CFG_SVH
`define UART6551_CFG_SVH

// reference clock feeding the baud generator
`define UART_CLK_HZ 40000000

// width of the 16x divisor and its counter
`define UART_CNT_BITS 24

// baud index after reset, 9600 baud
`define UART_RESET_BAUD 5'd14

`endif
